//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_cpu -f tb.f -Mdir obj_dir
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decode(
	input wire clk,
	input wire i_rst_n,
	input wire [cpu_pkg::XLEN-1:0] i_instr,
	input wire [cpu_pkg::XLEN-1:0] i_pc_plus_4,
	input wire i_fetched,
	output logic [cpu_pkg::REG_SEL_W-1:0] o_ra_sel,
	output logic [cpu_pkg::REG_SEL_W-1:0] o_rb_sel,
	dec_exec_if.src de
);
	import cpu_pkg::*;

	opcode_e opc;
	instr_class_e cls;
	dec_ctrl_t ctrl;
	logic [XLEN-1:0] imm32;

	assign opc = opcode_e'(i_instr[31:28]);
	assign cls = instr_class(opc);
	assign imm32 = {{16{i_instr[15]}}, i_instr[15:0]};

	// STW and BEQ take their second source from the rd field.
	assign o_ra_sel = i_instr[23:20];
	assign o_rb_sel = (opc == OP_STW || opc == OP_BEQ) ? i_instr[27:24] : i_instr[19:16];

	always_comb begin
		ctrl = '0;
		ctrl.is_branch = cls == CLASS_BRANCH;
		ctrl.is_cond = opc == OP_BEQ;
		ctrl.mem_load = opc == OP_LDW;
		ctrl.mem_store = opc == OP_STW;
		ctrl.update_rd = opc inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LDW};
		case (opc)
			OP_ADD: ctrl.alu_op = ALU_ADD;
			OP_SUB: ctrl.alu_op = ALU_SUB;
			OP_AND: ctrl.alu_op = ALU_AND;
			OP_OR: ctrl.alu_op = ALU_OR;
			OP_XOR: ctrl.alu_op = ALU_XOR;
			OP_ADDI, OP_LDW, OP_STW: begin
				ctrl.alu_op = ALU_ADD;
				ctrl.op2_imm = 1'b1;
			end
			default: ctrl.alu_op = ALU_PASS_B;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			de.valid <= 1'b0;
			de.ctrl <= dec_ctrl_t'('0);
		end else begin
			de.valid <= i_fetched;
			de.ctrl <= i_fetched ? ctrl : dec_ctrl_t'('0);
		end
	end

	always_ff @(posedge clk) begin
		de.rd_sel <= i_instr[27:24];
		de.imm32 <= imm32;
		de.pc_plus_4 <= i_pc_plus_4;
	end

endmodule

`default_nettype wire

//--- cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute(
	input wire clk,
	input wire i_rst_n,
	dec_exec_if.dst de,
	exec_mem_if.src em,
	output logic o_branch_taken,
	output logic [cpu_pkg::XLEN-1:0] o_branch_pc,
	output logic o_stall_clear
);
	import cpu_pkg::*;

	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_out;
	logic branch_resolve;
	logic operands_equal;

	assign op_b = de.ctrl.op2_imm ? de.imm32 : de.rb_val;
	assign operands_equal = de.ra_val == de.rb_val;

	always_comb begin
		case (de.ctrl.alu_op)
			ALU_ADD: alu_out = de.ra_val + op_b;
			ALU_SUB: alu_out = de.ra_val - op_b;
			ALU_AND: alu_out = de.ra_val & op_b;
			ALU_OR: alu_out = de.ra_val | op_b;
			ALU_XOR: alu_out = de.ra_val ^ op_b;
			default: alu_out = op_b;
		endcase
	end

	// Fetch waits on every branch, taken or not.
	assign branch_resolve = de.valid && de.ctrl.is_branch;
	assign o_stall_clear = branch_resolve;
	assign o_branch_taken = branch_resolve && (!de.ctrl.is_cond || operands_equal);
	assign o_branch_pc = de.pc_plus_4 + de.imm32;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			em.valid <= 1'b0;
			em.mem_load <= 1'b0;
			em.mem_store <= 1'b0;
			em.update_rd <= 1'b0;
		end else begin
			em.valid <= de.valid;
			em.mem_load <= de.valid && de.ctrl.mem_load;
			em.mem_store <= de.valid && de.ctrl.mem_store;
			em.update_rd <= de.valid && de.ctrl.update_rd;
		end
	end

	always_ff @(posedge clk) begin
		em.rd_sel <= de.rd_sel;
		em.result <= alu_out;
		em.store_data <= de.rb_val;
	end

endmodule

`default_nettype wire

//--- cpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch(
	input wire clk,
	input wire i_rst_n,
	input wire [cpu_pkg::XLEN-1:0] i_i_data,
	input wire i_i_ack,
	input wire i_stall_clear,
	input wire i_branch_taken,
	input wire [cpu_pkg::XLEN-1:0] i_branch_pc,
	output logic o_i_access,
	output logic [cpu_pkg::XLEN-1:0] o_i_addr,
	output logic [cpu_pkg::XLEN-1:0] o_instr,
	output logic [cpu_pkg::XLEN-1:0] o_pc_plus_4,
	output logic o_fetched,
	output logic o_halt
);
	import cpu_pkg::*;

	logic [XLEN-1:0] pc;
	logic stalled;
	logic ack_seen;
	instr_class_e ack_class;

	assign o_i_addr = pc;
	assign ack_seen = o_i_access && i_i_ack;
	assign ack_class = instr_class(opcode_e'(i_i_data[31:28]));

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pc <= RESET_PC;
			o_i_access <= 1'b0;
			o_fetched <= 1'b0;
			o_halt <= 1'b0;
			stalled <= 1'b0;
		end else begin
			o_fetched <= ack_seen;
			if (ack_seen) begin
				pc <= pc + 32'd4;
				case (ack_class)
					CLASS_MEM, CLASS_BRANCH: begin
						o_i_access <= 1'b0; // Wait for execute or memory to resolve it.
						stalled <= 1'b1;
					end
					CLASS_HALT: begin
						o_i_access <= 1'b0;
						o_halt <= 1'b1;
					end
					default: o_i_access <= 1'b1;
				endcase
			end else if (stalled) begin
				if (i_stall_clear) begin
					stalled <= 1'b0;
					o_i_access <= 1'b1;
					if (i_branch_taken)
						pc <= i_branch_pc;
				end
			end else if (!o_halt) begin
				o_i_access <= 1'b1; // First request after reset.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ack_seen) begin
			o_instr <= i_i_data;
			o_pc_plus_4 <= pc + 32'd4;
		end
	end

endmodule

`default_nettype wire

//--- cpu_memory.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_memory(
	input wire clk,
	input wire i_rst_n,
	exec_mem_if.dst em,
	input wire [cpu_pkg::XLEN-1:0] i_d_data,
	input wire i_d_ack,
	output logic o_d_access,
	output logic [cpu_pkg::XLEN-1:0] o_d_addr,
	output logic o_d_wr_en,
	output logic [cpu_pkg::XLEN-1:0] o_d_wr_data,
	output logic o_wb_en,
	output logic [cpu_pkg::REG_SEL_W-1:0] o_wb_sel,
	output logic [cpu_pkg::XLEN-1:0] o_wb_val,
	output logic o_complete,
	output logic o_busy
);
	import cpu_pkg::*;

	typedef enum logic {MEM_IDLE, MEM_WAIT} mem_state_e;

	mem_state_e state;
	logic store_q;
	logic [REG_SEL_W-1:0] rd_q;
	logic [XLEN-1:0] addr_q;
	logic [XLEN-1:0] wdata_q;
	logic start;
	logic alu_wb;
	logic load_wb;

	assign start = state == MEM_IDLE && (em.mem_load || em.mem_store);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= MEM_IDLE;
			store_q <= 1'b0;
		end else if (start) begin
			state <= MEM_WAIT;
			store_q <= em.mem_store;
		end else if (state == MEM_WAIT && i_d_ack) begin
			state <= MEM_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q <= em.result;
			wdata_q <= em.store_data;
			rd_q <= em.rd_sel;
		end
	end

	assign o_busy = state == MEM_WAIT;
	assign o_d_access = o_busy; // Held until the ack.
	assign o_d_addr = addr_q;
	assign o_d_wr_en = o_busy && store_q;
	assign o_d_wr_data = wdata_q;
	assign o_complete = o_busy && i_d_ack;

	// Fetch stalls behind a memory op, so the two writeback sources never collide.
	assign alu_wb = em.valid && em.update_rd && !em.mem_load && !em.mem_store;
	assign load_wb = o_complete && !store_q;
	assign o_wb_en = alu_wb || load_wb;
	assign o_wb_sel = load_wb ? rd_q : em.rd_sel;
	assign o_wb_val = load_wb ? i_d_data : em.result;

endmodule

`default_nettype wire

//--- cpu_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_pipeline(
	input wire clk,
	input wire i_rst_n,
	output logic o_i_access,
	output logic [cpu_pkg::XLEN-1:0] o_i_addr,
	input wire [cpu_pkg::XLEN-1:0] i_i_data,
	input wire i_i_ack,
	output logic o_d_access,
	output logic [cpu_pkg::XLEN-1:0] o_d_addr,
	output logic o_d_wr_en,
	output logic [cpu_pkg::XLEN-1:0] o_d_wr_data,
	input wire [cpu_pkg::XLEN-1:0] i_d_data,
	input wire i_d_ack,
	input wire [cpu_pkg::REG_SEL_W-1:0] i_dbg_reg_sel,
	output logic [cpu_pkg::XLEN-1:0] o_dbg_reg_val,
	output logic o_halted
);
	import cpu_pkg::*;

	logic [XLEN-1:0] fd_instr;
	logic [XLEN-1:0] fd_pc_plus_4;
	logic fd_fetched;
	logic fetch_halt;
	logic branch_taken;
	logic [XLEN-1:0] branch_pc;
	logic exec_stall_clear;
	logic mem_complete;
	logic mem_busy;
	logic [REG_SEL_W-1:0] d_ra_sel;
	logic [REG_SEL_W-1:0] d_rb_sel;
	logic [XLEN-1:0] rf_ra;
	logic [XLEN-1:0] rf_rb;
	logic [XLEN-1:0] rf_ra_q; // Register file read at the end of decode.
	logic [XLEN-1:0] rf_rb_q;
	logic wb_en;
	logic [REG_SEL_W-1:0] wb_sel;
	logic [XLEN-1:0] wb_val;
	logic [XLEN-1:0] wb_val_q;
	logic ra_fwd_exec;
	logic ra_fwd_mem;
	logic rb_fwd_exec;
	logic rb_fwd_mem;

	dec_exec_if de_bus();
	exec_mem_if em_bus();

	cpu_fetch u_fetch(.clk(clk), .i_rst_n(i_rst_n),
		.i_i_data(i_i_data), .i_i_ack(i_i_ack),
		.i_stall_clear(exec_stall_clear | mem_complete),
		.i_branch_taken(branch_taken), .i_branch_pc(branch_pc),
		.o_i_access(o_i_access), .o_i_addr(o_i_addr),
		.o_instr(fd_instr), .o_pc_plus_4(fd_pc_plus_4),
		.o_fetched(fd_fetched), .o_halt(fetch_halt));

	cpu_decode u_decode(.clk(clk), .i_rst_n(i_rst_n),
		.i_instr(fd_instr), .i_pc_plus_4(fd_pc_plus_4), .i_fetched(fd_fetched),
		.o_ra_sel(d_ra_sel), .o_rb_sel(d_rb_sel), .de(de_bus.src));

	cpu_execute u_execute(.clk(clk), .i_rst_n(i_rst_n),
		.de(de_bus.dst), .em(em_bus.src),
		.o_branch_taken(branch_taken), .o_branch_pc(branch_pc),
		.o_stall_clear(exec_stall_clear));

	cpu_memory u_memory(.clk(clk), .i_rst_n(i_rst_n), .em(em_bus.dst),
		.i_d_data(i_d_data), .i_d_ack(i_d_ack),
		.o_d_access(o_d_access), .o_d_addr(o_d_addr),
		.o_d_wr_en(o_d_wr_en), .o_d_wr_data(o_d_wr_data),
		.o_wb_en(wb_en), .o_wb_sel(wb_sel), .o_wb_val(wb_val),
		.o_complete(mem_complete), .o_busy(mem_busy));

	cpu_regfile u_regfile(.clk(clk), .i_rst_n(i_rst_n),
		.i_ra_sel(d_ra_sel), .i_rb_sel(d_rb_sel),
		.i_wr_en(wb_en), .i_wr_sel(wb_sel), .i_wr_val(wb_val),
		.i_dbg_sel(i_dbg_reg_sel),
		.o_ra(rf_ra), .o_rb(rf_rb), .o_dbg_val(o_dbg_reg_val));

	// Compare the decode sources with the ops in execute and memory.
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ra_fwd_exec <= 1'b0;
			ra_fwd_mem <= 1'b0;
			rb_fwd_exec <= 1'b0;
			rb_fwd_mem <= 1'b0;
		end else begin
			ra_fwd_exec <= de_bus.valid && de_bus.ctrl.update_rd && de_bus.rd_sel == d_ra_sel;
			ra_fwd_mem <= wb_en && wb_sel == d_ra_sel;
			rb_fwd_exec <= de_bus.valid && de_bus.ctrl.update_rd && de_bus.rd_sel == d_rb_sel;
			rb_fwd_mem <= wb_en && wb_sel == d_rb_sel;
		end
	end

	always_ff @(posedge clk) begin
		rf_ra_q <= rf_ra;
		rf_rb_q <= rf_rb;
		wb_val_q <= wb_val;
	end

	assign de_bus.ra_val = ra_fwd_exec ? em_bus.result : ra_fwd_mem ? wb_val_q : rf_ra_q;
	assign de_bus.rb_val = rb_fwd_exec ? em_bus.result : rb_fwd_mem ? wb_val_q : rf_rb_q;

	assign o_halted = fetch_halt && !fd_fetched && !de_bus.valid && !em_bus.valid && !mem_busy;

endmodule

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 32;
	localparam int REG_SEL_W = 4;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_AND = 4'h2,
		OP_OR = 4'h3,
		OP_XOR = 4'h4,
		OP_ADDI = 4'h5,
		OP_LDW = 4'h6,
		OP_STW = 4'h7,
		OP_BEQ = 4'h8,
		OP_JMP = 4'h9,
		OP_HALT = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		CLASS_ALU, CLASS_MEM, CLASS_BRANCH, CLASS_HALT
	} instr_class_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic op2_imm; // Operand 2 is the sign-extended immediate.
		logic mem_load;
		logic mem_store;
		logic is_branch;
		logic is_cond; // Branch taken only when ra equals rb.
		logic update_rd;
	} dec_ctrl_t;

	// Unknown opcodes fall into the ALU class so fetch keeps streaming.
	function automatic instr_class_e instr_class(opcode_e opc);
		case (opc)
			OP_LDW, OP_STW: return CLASS_MEM;
			OP_BEQ, OP_JMP: return CLASS_BRANCH;
			OP_HALT: return CLASS_HALT;
			default: return CLASS_ALU;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile(
	input wire clk,
	input wire i_rst_n,
	input wire [cpu_pkg::REG_SEL_W-1:0] i_ra_sel,
	input wire [cpu_pkg::REG_SEL_W-1:0] i_rb_sel,
	input wire i_wr_en,
	input wire [cpu_pkg::REG_SEL_W-1:0] i_wr_sel,
	input wire [cpu_pkg::XLEN-1:0] i_wr_val,
	input wire [cpu_pkg::REG_SEL_W-1:0] i_dbg_sel,
	output logic [cpu_pkg::XLEN-1:0] o_ra,
	output logic [cpu_pkg::XLEN-1:0] o_rb,
	output logic [cpu_pkg::XLEN-1:0] o_dbg_val
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs [2**REG_SEL_W];

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 2**REG_SEL_W; i++) begin
				regs[REG_SEL_W'(i)] <= '0;
			end
		end else if (i_wr_en) begin
			regs[i_wr_sel] <= i_wr_val;
		end
	end

	// A write in the same cycle is seen by the readers.
	assign o_ra = (i_wr_en && i_wr_sel == i_ra_sel) ? i_wr_val : regs[i_ra_sel];
	assign o_rb = (i_wr_en && i_wr_sel == i_rb_sel) ? i_wr_val : regs[i_rb_sel];
	assign o_dbg_val = regs[i_dbg_sel];

endmodule

`default_nettype wire

//--- stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_exec_if;
	import cpu_pkg::*;

	logic valid;
	dec_ctrl_t ctrl;
	logic [REG_SEL_W-1:0] rd_sel;
	logic [XLEN-1:0] imm32;
	logic [XLEN-1:0] pc_plus_4;
	logic [XLEN-1:0] ra_val; // Operands come from the forwarding mux in the top.
	logic [XLEN-1:0] rb_val;

	modport src(output valid, ctrl, rd_sel, imm32, pc_plus_4);
	modport dst(input valid, ctrl, rd_sel, imm32, pc_plus_4, ra_val, rb_val);
endinterface

interface exec_mem_if;
	import cpu_pkg::*;

	logic valid;
	logic mem_load;
	logic mem_store;
	logic update_rd;
	logic [REG_SEL_W-1:0] rd_sel;
	logic [XLEN-1:0] result; // Also the address of a load or store.
	logic [XLEN-1:0] store_data;

	modport src(output valid, mem_load, mem_store, update_rd, rd_sel, result, store_data);
	modport dst(input valid, mem_load, mem_store, update_rd, rd_sel, result, store_data);
endinterface

`default_nettype wire

//--- tb.f
cpu_pkg.sv
stage_if.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_memory.sv
cpu_regfile.sv
cpu_pipeline.sv
tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	localparam int MEM_WORDS = 64;
	localparam int SEED = 32'h3b99;
	localparam int TIMEOUT = 2000;

	logic clk = 1'b0;
	logic i_rst_n;
	logic o_i_access;
	logic [31:0] o_i_addr;
	logic [31:0] i_i_data;
	logic i_i_ack;
	logic o_d_access;
	logic [31:0] o_d_addr;
	logic o_d_wr_en;
	logic [31:0] o_d_wr_data;
	logic [31:0] i_d_data;
	logic i_d_ack;
	logic [3:0] i_dbg_reg_sel;
	logic [31:0] o_dbg_reg_val;
	logic o_halted;

	logic [31:0] imem [MEM_WORDS];
	logic [31:0] dmem [MEM_WORDS];
	logic [31:0] exp_mem [MEM_WORDS];
	logic [31:0] exp_regs [16];
	int prog_len;
	int errors;
	bit i_random;
	bit d_random;
	bit i_pending;
	bit d_pending;
	int i_wait;
	int d_wait;
	int store_count;
	int load_count;
	logic [31:0] store_addr;
	logic [31:0] store_data;

	cpu_pipeline i_dut(.*);

	initial begin
		forever #10 clk = ~clk;
	end

	// Instruction memory. Each request waits 0 to 3 cycles when i_random is set.
	always @(negedge clk) begin
		i_i_ack = 1'b0;
		if (!i_rst_n || !o_i_access) begin
			i_pending = 1'b0;
		end else begin
			if (!i_pending) begin
				i_pending = 1'b1;
				i_wait = i_random ? $urandom % 4 : 0;
			end
			if (i_wait == 0) begin
				i_i_ack = 1'b1;
				i_i_data = imem[o_i_addr[7:2]];
				i_pending = 1'b0;
			end else begin
				i_wait--;
			end
		end
	end

	always @(negedge clk) begin
		i_d_ack = 1'b0;
		if (!i_rst_n || !o_d_access) begin
			d_pending = 1'b0;
		end else begin
			if (!d_pending) begin
				d_pending = 1'b1;
				d_wait = d_random ? $urandom % 4 : 0;
			end
			if (d_wait == 0) begin
				i_d_ack = 1'b1;
				d_pending = 1'b0;
				if (o_d_wr_en) begin
					dmem[o_d_addr[7:2]] = o_d_wr_data;
					store_count++;
					store_addr = o_d_addr; // Kept for the store checks.
					store_data = o_d_wr_data;
				end else begin
					i_d_data = dmem[o_d_addr[7:2]];
					load_count++;
				end
			end else begin
				d_wait--;
			end
		end
	end

	function automatic logic [31:0] ri(input logic [3:0] op, input int rd, input int ra,
			input int imm);
		return {op, rd[3:0], ra[3:0], 4'h0, imm[15:0]};
	endfunction

	function automatic logic [31:0] rr(input logic [3:0] op, input int rd, input int ra,
			input int rb);
		return {op, rd[3:0], ra[3:0], rb[3:0], 16'h0};
	endfunction

	function automatic logic [31:0] fill_word(input int i);
		return 32'h5a5a_0000 ^ (32'(i) << 2);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic emit(input logic [31:0] w);
		imem[6'(prog_len)] = w;
		prog_len++;
	endtask

	task automatic new_program();
		prog_len = 0;
		store_count = 0;
		load_count = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			dmem[6'(i)] = fill_word(i);
		end
	endtask

	// Runs the program at instruction level to get the final registers and memory.
	task automatic run_model();
		logic [31:0] r [16];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] sum;
		logic [31:0] pc;
		bit done;
		int steps;
		for (int i = 0; i < 16; i++) begin
			r[4'(i)] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			exp_mem[6'(i)] = fill_word(i);
		end
		pc = RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			w = imem[pc[7:2]];
			a = r[w[23:20]];
			b = r[w[19:16]];
			imm = {{16{w[15]}}, w[15:0]};
			sum = a + imm; // Also the address of a load or store.
			pc = pc + 32'd4;
			steps++;
			case (opcode_e'(w[31:28]))
				OP_ADD: r[w[27:24]] = a + b;
				OP_SUB: r[w[27:24]] = a - b;
				OP_AND: r[w[27:24]] = a & b;
				OP_OR: r[w[27:24]] = a | b;
				OP_XOR: r[w[27:24]] = a ^ b;
				OP_ADDI: r[w[27:24]] = sum;
				OP_LDW: r[w[27:24]] = exp_mem[sum[7:2]];
				OP_STW: exp_mem[sum[7:2]] = r[w[27:24]];
				OP_BEQ: if (a == r[w[27:24]]) pc = pc + imm;
				OP_JMP: pc = pc + imm;
				OP_HALT: done = 1'b1;
				default: ;
			endcase
		end
		exp_regs = r;
	endtask

	task automatic check_idle_outputs();
		check("o_i_access", 32'(o_i_access), 32'h0);
		check("o_d_access", 32'(o_d_access), 32'h0);
		check("o_d_wr_en", 32'(o_d_wr_en), 32'h0);
		check("o_halted", 32'(o_halted), 32'h0);
	endtask

	task automatic apply_reset();
		i_rst_n = 1'b0;
		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			check_idle_outputs();
		end
		i_rst_n = 1'b1;
	endtask

	task automatic wait_halted(input string name);
		int cycles;
		cycles = 0;
		while (!o_halted && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!o_halted) begin
			errors++;
			$display("Timeout in %s: the CPU did not halt within %0d cycles.", name, TIMEOUT);
		end
	endtask

	task automatic read_reg(input int r, output logic [31:0] val);
		@(negedge clk);
		i_dbg_reg_sel = 4'(r);
		#1;
		val = o_dbg_reg_val;
	endtask

	task automatic check_regs(input string name);
		logic [31:0] val;
		for (int r = 0; r < 16; r++) begin
			read_reg(r, val);
			check($sformatf("o_dbg_reg_val r%0d (%s)", r, name), val, exp_regs[4'(r)]);
		end
	endtask

	task automatic run_program(input string name);
		run_model();
		apply_reset();
		wait_halted(name);
		check_regs(name);
	endtask

	task automatic reset_and_first_fetch();
		int cycles;
		new_program();
		emit(ri(OP_ADDI, 1, 0, 16'h00a5));
		emit(ri(OP_HALT, 0, 0, 0));
		run_model();
		apply_reset();
		check_idle_outputs();
		cycles = 0;
		while (!o_i_access && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (o_i_access) begin
			check("o_i_addr", o_i_addr, RESET_PC);
		end else begin
			errors++;
			$display("Timeout: no instruction request was made after reset.");
		end
		wait_halted("reset");
		check_regs("reset");
	endtask

	task automatic alu_dependency_chain();
		new_program();
		emit(ri(OP_ADDI, 1, 0, 5));
		emit(ri(OP_ADDI, 2, 1, 7)); // r1 at distance one.
		emit(rr(OP_ADD, 3, 2, 1)); // Distances one and two.
		emit(rr(OP_SUB, 4, 3, 1)); // r1 is now three behind.
		emit(rr(OP_AND, 5, 4, 2));
		emit(rr(OP_OR, 6, 5, 3));
		emit(rr(OP_XOR, 7, 6, 4));
		emit(ri(OP_ADDI, 8, 7, -3));
		emit(rr(OP_SUB, 9, 8, 6));
		emit(ri(OP_HALT, 0, 0, 0));
		run_program("alu chain");
	endtask

	task automatic store_load_round_trip();
		new_program();
		d_random = 1'b1;
		emit(ri(OP_ADDI, 1, 0, 16'h0040));
		emit(ri(OP_ADDI, 2, 0, 16'h1234));
		emit(rr(OP_XOR, 2, 2, 1));
		emit(ri(OP_STW, 2, 1, 8)); // Stores r2 at r1 + 8.
		emit(ri(OP_LDW, 3, 1, 8));
		emit(rr(OP_ADD, 4, 3, 3));
		emit(ri(OP_LDW, 5, 0, 16'h0010));
		emit(ri(OP_HALT, 0, 0, 0));
		run_program("store and load");
		check("stores seen with o_d_wr_en", 32'(store_count), 32'd1);
		check("o_d_addr of the store", store_addr, 32'h40 + 32'd8);
		check("o_d_wr_data of the store", store_data, exp_regs[4'd2]);
		check("loads seen", 32'(load_count), 32'd2);
		check("data memory word 0x48", dmem[6'd18], exp_mem[6'd18]);
		d_random = 1'b0;
	endtask

	task automatic branch_skips();
		new_program();
		emit(ri(OP_ADDI, 1, 0, 3));
		emit(ri(OP_ADDI, 2, 0, 3));
		emit(ri(OP_ADDI, 3, 0, 9));
		emit(ri(OP_BEQ, 2, 1, 4)); // Taken, skips the next word.
		emit(ri(OP_ADDI, 3, 0, 16'h0077));
		emit(ri(OP_JMP, 0, 0, 8));
		emit(ri(OP_ADDI, 4, 0, 16'h0055));
		emit(ri(OP_ADDI, 3, 3, 1));
		emit(ri(OP_BEQ, 3, 1, 4)); // Not taken.
		emit(ri(OP_ADDI, 5, 0, 16'h0066));
		emit(ri(OP_ADDI, 6, 1, 1));
		emit(ri(OP_HALT, 0, 0, 0));
		run_program("branches");
	endtask

	task automatic fetch_backpressure();
		opcode_e ops [6];
		logic [31:0] w;
		ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
		new_program();
		for (int n = 0; n < 48; n++) begin
			w = $urandom;
			w[31:28] = ops[3'($urandom % 6)];
			emit(w);
		end
		emit(ri(OP_HALT, 0, 0, 0));
		i_random = 1'b0;
		run_program("alu burst, immediate ack");
		i_random = 1'b1;
		run_program("alu burst, random ack");
		i_random = 1'b0;
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_i_data = '0;
		i_i_ack = 1'b0;
		i_d_data = '0;
		i_d_ack = 1'b0;
		i_dbg_reg_sel = '0;
		i_random = 1'b0;
		d_random = 1'b0;
		i_pending = 1'b0;
		d_pending = 1'b0;
		i_wait = 0;
		d_wait = 0;
		errors = 0;
		store_addr = '0;
		store_data = '0;
		void'($urandom(SEED));
		reset_and_first_fetch();
		alu_dependency_chain();
		store_load_round_trip();
		branch_skips();
		fetch_backpressure();
		$display("Run complete with %0d errors.", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
